//--- useq_top.f
+incdir+hdl
hdl/useq_pkg.sv
hdl/micro_pc.sv
hdl/opcode_map.sv
hdl/cond_select.sv
hdl/control_store.sv
hdl/useq_control.sv
hdl/useq_top.sv
dv/useq_tb.sv

//--- dv/useq_trace.txt
// restart jam go_n opcode status | expected microaddress ctrl eil_n
// One line per clock, all values in hex
0 0 1 0 0 00 000 1
0 0 1 0 0 01 001 1
0 0 1 0 0 00 000 1
0 0 0 0 0 01 001 1
0 0 0 3 0 02 002 0
0 0 0 3 0 30 030 1
0 0 0 3 0 31 031 1
0 0 0 3 0 00 000 1
0 0 0 7 5 01 001 1
0 0 0 A 0 02 002 0
0 0 1 A 0 A0 0A0 1
0 0 1 A 0 A1 0A1 1
0 0 0 F 0 00 000 1
0 0 0 F 0 01 001 1
0 0 0 F 0 02 002 0
0 0 0 F 0 F0 0F0 1
0 0 0 F 0 F1 0F1 1
0 0 0 5 0 00 000 1
0 1 0 5 0 FF 7FF 1
0 1 1 5 0 FF 7FF 1
0 0 0 5 0 01 001 1
0 1 0 5 0 FF 7FF 1
0 0 0 5 0 02 002 0
0 0 0 5 0 50 050 1
0 1 0 5 0 FF 7FF 1
0 0 0 5 0 51 051 1
0 0 0 0 0 00 000 1
1 0 0 0 0 01 001 1
0 0 0 0 0 00 000 1
0 0 0 C 0 01 001 1
1 0 0 C 0 02 002 0
0 0 0 C 0 00 000 1
0 0 0 C 0 01 001 1
0 0 0 C 0 02 002 0
1 1 0 C 0 FF 7FF 1
0 0 1 C 0 00 000 1
0 0 1 C 0 01 001 1

//--- dv/useq_tb.sv
//**********************************************************
// Trace-driven testbench for the microprogram sequencer
// Run from the project root so that dv/useq_trace.txt is found
// Inputs change on the falling edge, outputs are checked before the rising edge
//**********************************************************
`timescale 1ns/1ns
`include "useq_consts.svh"

module useq_tb;

    localparam int    MAX_LINES  = 256;
    localparam int    FIELDS     = 8;
    localparam string TRACE_FILE = "dv/useq_trace.txt";

    // One trace line, inputs first and then expected outputs
    typedef struct packed {
        logic                    restart;
        logic                    jam;
        logic                    go_n;
        logic [3:0]              opcode;
        logic [3:0]              status;
        logic [`USEQ_ADDR_W-1:0] addr;
        logic [`USEQ_CTRL_W-1:0] ctrl;
        logic                    eil_n;
    } trace_line_t;

    logic                    system_clk;
    logic                    arst_n;
    logic                    restart;
    logic [3:0]              opcode;
    logic [3:0]              status;
    logic                    go_n;
    logic                    jam;
    logic [`USEQ_ADDR_W-1:0] microaddress;
    logic [`USEQ_CTRL_W-1:0] ctrl;
    logic                    eil_n;

    logic [31:0] raw [FIELDS*MAX_LINES];
    int          n_lines;
    int          cur_line;
    logic        trace_ready;
    trace_line_t cur;

    useq_top u_dut (
        .system_clk   (system_clk),
        .arst_n       (arst_n),
        .restart      (restart),
        .opcode       (opcode),
        .status       (status),
        .go_n         (go_n),
        .jam          (jam),
        .microaddress (microaddress),
        .ctrl         (ctrl),
        .eil_n        (eil_n)
    );

    initial begin
        system_clk = 1'b0;
        forever #5 system_clk = ~system_clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped on the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("Error: %s is 0x%0h, expected 0x%0h (trace line %0d)",
                                name, actual, expected, cur_line));
        end
    endtask

    function automatic trace_line_t line_from_raw(input int n);
        trace_line_t t;
        t.restart = raw[FIELDS*n][0];
        t.jam     = raw[FIELDS*n+1][0];
        t.go_n    = raw[FIELDS*n+2][0];
        t.opcode  = raw[FIELDS*n+3][3:0];
        t.status  = raw[FIELDS*n+4][3:0];
        t.addr    = raw[FIELDS*n+5][`USEQ_ADDR_W-1:0];
        t.ctrl    = raw[FIELDS*n+6][`USEQ_CTRL_W-1:0];
        t.eil_n   = raw[FIELDS*n+7][0];
        return t;
    endfunction

    task automatic load_trace();
        int fd;
        int k;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            abort_run("The trace file dv/useq_trace.txt is missing or cannot be read");
        end
        else begin
            $fclose(fd);
            // Words the file did not fill keep FFFF in the upper half
            for (k = 0; k < FIELDS*MAX_LINES; k++) begin
                raw[k] = 32'hFFFF_0000 | k;
            end
            $readmemh(TRACE_FILE, raw);
            n_lines = 0;
            while (n_lines < MAX_LINES && raw[FIELDS*n_lines][31:16] != 16'hFFFF) begin
                n_lines++;
            end
            if (n_lines == 0) begin
                abort_run("The trace file holds no test lines");
            end
            else begin
                trace_ready = 1'b1;
            end
        end
    endtask

    // Stimulus and checks
    initial begin
        trace_ready = 1'b0;
        cur_line    = 0;
        arst_n      = 1'b0;
        restart     = 1'b0;
        jam         = 1'b0;
        go_n        = 1'b1;
        opcode      = 4'h0;
        status      = 4'h0;
        load_trace();
        repeat (3) @(posedge system_clk);
        // The first line sees the counter straight out of reset
        @(negedge system_clk);
        arst_n = 1'b1;
        for (int i = 0; i < n_lines; i++) begin
            cur_line = i + 1;
            cur      = line_from_raw(i);
            restart  = cur.restart;
            jam      = cur.jam;
            go_n     = cur.go_n;
            opcode   = cur.opcode;
            status   = cur.status;
            #2;
            check_value("microaddress", microaddress, cur.addr);
            check_value("ctrl", ctrl, cur.ctrl);
            check_value("eil_n", eil_n, cur.eil_n);
            @(negedge system_clk);
        end
        $display("STATUS: PASS");
        $finish;
    end

    // Watchdog, sized from the trace plus reset and margin
    initial begin
        wait (trace_ready);
        #((n_lines + 10) * 10);
        abort_run("Timeout: the trace did not finish in the expected time");
    end

endmodule

//--- hdl/useq_top.sv
//**********************************************************
// Microprogram sequencer top level
// One microinstruction per clock and no handshakes
// Control bits go out unregistered with the microaddress
//**********************************************************
`timescale 1ns/1ns
`include "useq_consts.svh"

module useq_top (
    input  logic                    system_clk,
    input  logic                    arst_n,
    input  logic                    restart,
    input  logic [3:0]              opcode,
    input  logic [3:0]              status,
    input  logic                    go_n,
    input  logic                    jam,
    output logic [`USEQ_ADDR_W-1:0] microaddress,
    output logic [`USEQ_CTRL_W-1:0] ctrl,
    output logic                    eil_n
);

    useq_pkg::microword_t mw;

    // ROM address is the outgoing microaddress, jam included
    control_store u_store (
        .addr (microaddress),
        .mw   (mw)
    );

    useq_control u_ctrl (
        .system_clk   (system_clk),
        .arst_n       (arst_n),
        .restart      (restart),
        .opcode       (opcode),
        .status       (status),
        .go_n         (go_n),
        .jam          (jam),
        .mw           (mw),
        .microaddress (microaddress),
        .ctrl         (ctrl),
        .eil_n        (eil_n)
    );

endmodule

//--- hdl/useq_control.sv
//**********************************************************
// Sequencer control section
// Jam forces FF onto the microaddress and freezes the counter
// Restart still acts while jam is high
//**********************************************************
`timescale 1ns/1ns
`include "useq_consts.svh"

module useq_control (
    input  logic                    system_clk,
    input  logic                    arst_n,
    input  logic                    restart,
    input  logic [3:0]              opcode,
    input  logic [3:0]              status,
    input  logic                    go_n,
    input  logic                    jam,
    input  useq_pkg::microword_t    mw,
    output logic [`USEQ_ADDR_W-1:0] microaddress,
    output logic [`USEQ_CTRL_W-1:0] ctrl,
    output logic                    eil_n
);

    logic [`USEQ_ADDR_W-1:0] next_addr;
    logic [`USEQ_ADDR_W-1:0] mpc;
    logic                    cond_load;
    logic                    pc_load;
    logic                    pc_count;

    assign ctrl = mw.ctrl;

    // The jam word must not steer the counter
    assign pc_load  = cond_load & ~jam;
    assign pc_count = mw.count & ~jam;

    micro_pc u_mpc (
        .system_clk (system_clk),
        .arst_n     (arst_n),
        .restart    (restart),
        .load       (pc_load),
        .count      (pc_count),
        .next_addr  (next_addr),
        .mpc        (mpc)
    );

    opcode_map u_map (
        .opcode    (opcode),
        .addr_hi   (mw.addr_hi),
        .addr_lo   (mw.addr_lo),
        .next_addr (next_addr),
        .eil_n     (eil_n)
    );

    cond_select u_cond (
        .system_clk (system_clk),
        .arst_n     (arst_n),
        .status     (status),
        .go_n       (go_n),
        .bop        (mw.bop),
        .load       (cond_load)
    );

    assign microaddress = jam ? `USEQ_JAM_ADDR : mpc;

endmodule

//--- hdl/control_store.sv
//**********************************************************
// Fixed microprogram ROM, read combinationally
// Unlisted words jump to 00 with all control bits set
//**********************************************************
`timescale 1ns/1ns
`include "useq_consts.svh"

module control_store (
    input  logic [`USEQ_ADDR_W-1:0] addr,
    output useq_pkg::microword_t    mw
);

    if ($bits(useq_pkg::microword_t) != `USEQ_MW_W) begin : g_width_check
        $error("Microword struct is not %0d bits wide", `USEQ_MW_W);
    end

    always_comb begin
        // Unconditional jump to 00 unless a word says otherwise
        mw              = '0;
        mw.ctrl         = {{(`USEQ_CTRL_W-`USEQ_ADDR_W){1'b0}}, addr};
        mw.bop.polarity = 1'b1;
        mw.bop.sel      = useq_pkg::sel_never1;
        casez (addr)
            8'h00: begin
                mw.bop.polarity = 1'b0;
                mw.count        = 1'b1;
            end
            8'h01: begin
                // Wait here while go_n is high
                mw.bop.polarity = 1'b0;
                mw.bop.sel      = useq_pkg::sel_go_n;
                mw.count        = 1'b1;
            end
            8'h02: begin
                mw.addr_hi = `USEQ_DISPATCH_HI;
            end
            8'b????_0000: begin
                // First word of an opcode page
                mw.bop.polarity = 1'b0;
                mw.count        = 1'b1;
            end
            8'b????_0001: begin
                // Page exit, back to fetch
            end
            default: begin
                mw.ctrl = '1;
            end
        endcase
    end

endmodule

//--- hdl/cond_select.sv
//**********************************************************
// Branch condition mux with polarity
// load is high when the selected condition differs from polarity
//**********************************************************
`timescale 1ns/1ns

module cond_select (
    input  logic               system_clk,
    input  logic               arst_n,
    input  logic [3:0]         status,
    input  logic               go_n,
    input  useq_pkg::bop_t     bop,
    output logic               load
);

    logic cond;

    always_comb begin
        case (bop.sel)
            useq_pkg::sel_status2: cond = status[2];
            useq_pkg::sel_status0: cond = status[0];
            useq_pkg::sel_status1: cond = status[1];
            useq_pkg::sel_go_n:    cond = go_n;
            useq_pkg::sel_status3: cond = status[3];
            // Tied-low slots
            default:               cond = 1'b0;
        endcase
    end

    // Polarity 1 on a low slot gives an unconditional jump
    assign load = cond ^ bop.polarity;

    // Select comes straight from the control store word
    sel_known_a : assert property (
        @(posedge system_clk) disable iff (!arst_n)
        !$isunknown(bop.sel)
    );

endmodule

//--- hdl/opcode_map.sv
//**********************************************************
// Forms the load target from the microword or the opcode
// eil_n is active low and tracks the dispatch marker only
//**********************************************************
`timescale 1ns/1ns
`include "useq_consts.svh"

module opcode_map (
    input  logic [3:0]              opcode,
    input  logic [3:0]              addr_hi,
    input  logic [3:0]              addr_lo,
    output logic [`USEQ_ADDR_W-1:0] next_addr,
    output logic                    eil_n
);

    logic       dispatch;
    logic [3:0] page;

    // Marker in the high field means jump to the opcode page
    assign dispatch = (addr_hi == `USEQ_DISPATCH_HI);

    assign page = dispatch ? opcode : addr_hi;

    assign next_addr = {page, addr_lo};

    // Latch the next instruction while dispatching
    assign eil_n = ~dispatch;

endmodule

//--- hdl/micro_pc.sv
//**********************************************************
// Microprogram counter
// Restart wins over load, load wins over count
// Counting wraps from 255 to 0
//**********************************************************
`timescale 1ns/1ns
`include "useq_consts.svh"

module micro_pc (
    input  logic                    system_clk,
    input  logic                    arst_n,
    input  logic                    restart,
    input  logic                    load,
    input  logic                    count,
    input  logic [`USEQ_ADDR_W-1:0] next_addr,
    output logic [`USEQ_ADDR_W-1:0] mpc
);

    logic [`USEQ_ADDR_W-1:0] mpc_inc;

    assign mpc_inc = mpc + 1'b1;

    always_ff @(posedge system_clk or negedge arst_n) begin
        if (!arst_n) begin
            mpc <= '0;
        end
        else if (restart) begin
            mpc <= '0;
        end
        else if (load) begin
            // Branch or dispatch target
            mpc <= next_addr;
        end
        else if (count) begin
            mpc <= mpc_inc;
        end
    end

    // An unknown counter would send X into the control store
    // and from there into every control bit
    mpc_known_a : assert property (
        @(posedge system_clk) disable iff (!arst_n)
        !$isunknown(mpc)
    );

endmodule

//--- hdl/useq_pkg.sv
//**********************************************************
// Microword and branch field types
// Field order is MSB first and must match the 24-bit word
//**********************************************************
`include "useq_consts.svh"

package useq_pkg;

    // Condition slots in mux order
    // Slots 1, 6 and 7 are tied low
    typedef enum logic [2:0] {
        sel_status2 = 3'd0,
        sel_never1  = 3'd1,
        sel_status0 = 3'd2,
        sel_status1 = 3'd3,
        sel_go_n    = 3'd4,
        sel_status3 = 3'd5,
        sel_never6  = 3'd6,
        sel_never7  = 3'd7
    } cond_sel_e;

    // Branch operation
    typedef struct packed {
        logic      polarity;
        cond_sel_e sel;
    } bop_t;

    // One microword as read from the control store
    typedef struct packed {
        logic [`USEQ_CTRL_W-1:0] ctrl;
        bop_t                    bop;
        logic                    count;
        logic [3:0]              addr_hi;
        logic [3:0]              addr_lo;
    } microword_t;

endpackage

//--- hdl/useq_consts.svh
//**********************************************************
// Fixed microword layout for the sequencer
// Addresses are 8 bits and the control store has 256 words
//**********************************************************
`ifndef USEQ_CONSTS_SVH
`define USEQ_CONSTS_SVH

// Microaddress, microword and control field widths
`define USEQ_ADDR_W 8
`define USEQ_MW_W 24
`define USEQ_CTRL_W 11

// High field value that selects the opcode as target page
`define USEQ_DISPATCH_HI 4'hF

// Address forced onto the output while jam is high
`define USEQ_JAM_ADDR 8'hFF

`endif
